//--- sim/stepper_assertions.sv
`timescale 1ns/1ps

// Protocol checks, bound into the queue and the step generator
module stepper_assertions
  import stepper_pkg::*;
(
  input logic CLK,
  input logic reset,
  input logic push,
  input logic full,
  input logic step,
  input logic move_done,
  input logic busy
);

  // Read by the testbench at the end of the run
  int fail_count = 0;

  // A push into a full queue is silently lost
  no_push_when_full: assert property (@(posedge CLK) disable iff (reset) push |-> !full)
    else begin
      fail_count++;
      $error("move pushed while the queue was full");
    end

  // Step is a single cycle pulse
  step_single_cycle: assert property (@(posedge CLK) disable iff (reset) step |=> !step)
    else begin
      fail_count++;
      $error("step held high for two cycles");
    end

  // Done only once the timer has let go of the move
  done_when_idle: assert property (@(posedge CLK) disable iff (reset) move_done |-> !busy)
    else begin
      fail_count++;
      $error("move_done while a move was still active");
    end

endmodule

bind move_queue stepper_assertions u_queue_checks (
  .CLK(CLK),
  .reset(reset),
  .push(enq.push),
  .full(enq.full),
  .step(1'b0),
  .move_done(1'b0),
  .busy(1'b0)
);

bind dda_timer stepper_assertions u_timer_checks (
  .CLK(CLK),
  .reset(reset),
  .push(1'b0),
  .full(1'b0),
  .step(step),
  .move_done(move_done),
  .busy(busy)
);

//--- sim/stepper_monitor.sv
`timescale 1ns/1ps

// Watches the DUT pins and compares them with reference models
module stepper_monitor
  import stepper_pkg::*;
(
  input logic CLK,
  input logic reset,
  input logic sck,
  input logic cs,
  input logic copi,
  input logic cipo,
  input logic [63:0] encoder_count,
  input logic step,
  input logic dir,
  input logic enable,
  input logic move_done,
  input logic buffer_ready,
  input logic [7:0] current,
  input logic [2:0] microsteps
);

  string test_name = "none";
  int test_checks = 0;
  int test_errors = 0;
  int check_total = 0;
  int error_total = 0;
  // Completed moves, polled by the testbench
  int done_count = 0;

  // SPI sniffer, pins sampled on the falling CLK edge
  logic sck_prev = 1'b0;
  logic cs_prev = 1'b1;
  logic in_reset = 1'b1;
  int bit_count = 0;
  logic [63:0] rx_word;
  logic [63:0] tx_word;

  // Message state and config registers as the host sees them
  logic [7:0] msg_cmd = 8'd0;
  int word_index = 0;
  logic config_due = 1'b0;
  logic exp_enable = 1'b0;
  logic [7:0] exp_current = 8'd140;
  logic [2:0] exp_microsteps = 3'd2;
  logic [7:0] exp_divisor = 8'd40;
  logic [63:0] encoder_snapshot;
  logic move_dir;
  logic [63:0] move_duration;
  logic [63:0] move_increment;

  // One entry per move still in flight
  int exp_steps_q[$];
  logic exp_dir_q[$];
  int steps_seen = 0;
  // Cycle of the last step in the current move, negative when none yet
  int cycle_now = 0;
  int last_step_cycle = -1;

  task automatic start_test(input string name);
    test_name = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    // Every move sent in this test has to be done by now
    check("moves_pending", 64'd0, exp_steps_q.size());
    $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  task automatic check(input string what,
                       input logic [63:0] expected,
                       input logic [63:0] actual);
    test_checks++;
    check_total++;
    if (expected !== actual) begin
      test_errors++;
      error_total++;
      $display("Fail %s %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    test_errors++;
    error_total++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  // Second order DDA, rate bumped before each phase add
  function automatic int count_steps(input logic [63:0] duration,
                                     input logic [63:0] increment,
                                     input logic [63:0] rate_change);
    logic [63:0] rate;
    logic [63:0] phase;
    logic [64:0] sum;
    int steps;
    rate = increment;
    phase = '0;
    steps = 0;
    for (logic [63:0] t = 0; t < duration; t++) begin
      rate = rate + rate_change;
      sum = {1'b0, phase} + {1'b0, rate};
      // Carry out is one step
      if (sum[64]) begin
        steps++;
      end
      phase = sum[63:0];
    end
    return steps;
  endfunction

  // Runs at the 64th bit, before the DUT can act on the word
  task automatic handle_word(input logic [63:0] rx, input logic [63:0] tx);
    int steps;
    if (word_index == 0) begin
      msg_cmd = rx[63:56];
      // First words never carry a reply
      check("reply_zero", 64'd0, tx);
      config_due = 1'b1;
      case (rx[63:56])
        CMD_MOTOR_ENABLE: begin
          exp_enable = rx[0];
        end
        CMD_MOTORCONFIG: begin
          exp_current = rx[15:8];
          exp_microsteps = rx[2:0];
        end
        CMD_CLK_DIVISOR: begin
          // Only shows up in step timing
          exp_divisor = rx[7:0];
        end
        CMD_API_VERSION: begin
          word_index = 1;
          config_due = 1'b0;
        end
        CMD_COORDINATED_STEP: begin
          move_dir = rx[0];
          encoder_snapshot = encoder_count;
          word_index = 1;
          config_due = 1'b0;
        end
        default: begin
          // Unknown command, nothing to model
        end
      endcase
    end else if (msg_cmd == CMD_API_VERSION) begin
      // Major, minor, patch in the low three bytes, zeros above
      check("api_upper", 64'd0, tx[63:24]);
      check("api_major", VERSION_MAJOR, tx[23:16]);
      check("api_minor", VERSION_MINOR, tx[15:8]);
      check("api_patch", VERSION_PATCH, tx[7:0]);
      word_index = 0;
    end else if (word_index == 1) begin
      move_duration = rx;
      check("reply_zero", 64'd0, tx);
      word_index = 2;
    end else if (word_index == 2) begin
      move_increment = rx;
      check("reply_zero", 64'd0, tx);
      word_index = 3;
    end else begin
      // Encoder value from the header word comes back here
      check("encoder_reply", encoder_snapshot, tx);
      steps = count_steps(move_duration, move_increment, rx);
      exp_steps_q.push_back(steps);
      exp_dir_q.push_back(move_dir);
      word_index = 0;
    end
  endtask

  always @(negedge CLK) begin
    if (reset) begin
      in_reset = 1'b1;
    end else begin
      cycle_now++;
      if (in_reset) begin
        in_reset = 1'b0;
        check("enable", exp_enable, enable);
        check("current", exp_current, current);
        check("microsteps", exp_microsteps, microsteps);
        check("buffer_ready", 64'd1, buffer_ready);
        check("cipo", 64'd0, cipo);
      end
      // Mode 0, both lines sampled on the rising SCK
      if (!cs && sck && !sck_prev) begin
        rx_word = {rx_word[62:0], copi};
        tx_word = {tx_word[62:0], cipo};
        bit_count++;
        if (bit_count == WORD_BITS) begin
          handle_word(rx_word, tx_word);
        end
      end
      if (cs && !cs_prev) begin
        // Decoder has settled by the time CS rises
        if (config_due) begin
          check("enable", exp_enable, enable);
          check("current", exp_current, current);
          check("microsteps", exp_microsteps, microsteps);
          config_due = 1'b0;
        end
        if (bit_count != WORD_BITS) begin
          report_error("chip select rose in the middle of a word");
        end
        bit_count = 0;
      end
      if (step) begin
        steps_seen++;
        if (exp_dir_q.size() == 0) begin
          report_error("step pulse with no move pending");
        end else begin
          check("dir", exp_dir_q[0], dir);
        end
        // Steps only on ticks, one tick per divisor+1 cycles
        if (last_step_cycle >= 0) begin
          check("step_spacing", 64'd0,
                (cycle_now - last_step_cycle) % (exp_divisor + 1));
        end
        last_step_cycle = cycle_now;
      end
      if (move_done) begin
        if (exp_steps_q.size() == 0) begin
          report_error("move_done pulse with no move pending");
        end else begin
          check("step_count", exp_steps_q[0], steps_seen);
          void'(exp_steps_q.pop_front());
          void'(exp_dir_q.pop_front());
          done_count++;
        end
        steps_seen = 0;
        last_step_cycle = -1;
      end
    end
    sck_prev = sck;
    cs_prev = cs;
  end

endmodule

//--- sim/stepper_tb.sv
`timescale 1ns/1ps

// Top level testbench, SPI host plus random moves
module stepper_tb
  import stepper_pkg::*;
();

  localparam int CONFIG_ROUNDS = 4;
  localparam int API_ROUNDS = 2;
  localparam int RANDOM_MOVES = 8;
  localparam int FLOW_MOVES = 5;
  // Long enough that the queue fills while the first move runs
  localparam int FLOW_DURATION = 40;
  localparam int MAX_DURATION = FLOW_DURATION;
  // One SPI transfer including CS setup and hold
  localparam int WORD_CYCLES = 540;
  localparam int TOTAL_WORDS = 3 * CONFIG_ROUNDS + 2 * API_ROUNDS + 1 +
                               4 * (RANDOM_MOVES + FLOW_MOVES);
  // Worst case divisor 255, one tick per 256 cycles
  localparam int TIMEOUT_CYCLES = (RANDOM_MOVES + FLOW_MOVES) * (MAX_DURATION + 1) * 256 +
                                  TOTAL_WORDS * WORD_CYCLES + 200;

  logic CLK;
  logic reset;
  logic sck;
  logic cs;
  logic copi;
  logic [63:0] encoder_count;
  logic cipo;
  logic step;
  logic dir;
  logic enable;
  logic move_done;
  logic buffer_ready;
  logic [7:0] current;
  logic [2:0] microsteps;

  logic [31:0] lfsr_state;
  int cycle_count = 0;
  int moves_sent = 0;
  int assertion_fails;
  int error_count;

  stepper_controller i_stepper_controller (
    .CLK(CLK),
    .reset(reset),
    .sck(sck),
    .cs(cs),
    .copi(copi),
    .encoder_count(encoder_count),
    .cipo(cipo),
    .step(step),
    .dir(dir),
    .enable(enable),
    .move_done(move_done),
    .buffer_ready(buffer_ready),
    .current(current),
    .microsteps(microsteps)
  );

  stepper_monitor u_monitor (
    .CLK(CLK),
    .reset(reset),
    .sck(sck),
    .cs(cs),
    .copi(copi),
    .cipo(cipo),
    .encoder_count(encoder_count),
    .step(step),
    .dir(dir),
    .enable(enable),
    .move_done(move_done),
    .buffer_ready(buffer_ready),
    .current(current),
    .microsteps(microsteps)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Watchdog
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int count, output logic [63:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[62:0], lfsr_state[0]};
    end
  endtask

  // One 64 bit word, MSB first, SCK toggles every 4 CLK cycles
  task automatic spi_transfer(input logic [63:0] word);
    @(posedge CLK);
    cs <= 1'b0;
    repeat (8) @(posedge CLK);
    for (int i = WORD_BITS - 1; i >= 0; i--) begin
      copi <= word[i];
      repeat (4) @(posedge CLK);
      sck <= 1'b1;
      repeat (4) @(posedge CLK);
      sck <= 1'b0;
    end
    // Leave time for the decoder before the next frame
    repeat (8) @(posedge CLK);
    cs <= 1'b1;
    repeat (8) @(posedge CLK);
  endtask

  task automatic wait_buffer_ready();
    @(negedge CLK);
    while (!buffer_ready) begin
      @(negedge CLK);
    end
  endtask

  task automatic send_move(input logic move_dir,
                           input logic [63:0] duration,
                           input logic [63:0] increment,
                           input logic [63:0] rate_change);
    logic [63:0] position;
    wait_buffer_ready();
    // New encoder value for each move, steady during it
    random_bits(64, position);
    @(posedge CLK);
    encoder_count <= position;
    spi_transfer({CMD_COORDINATED_STEP, 55'd0, move_dir});
    spi_transfer(duration);
    spi_transfer(increment);
    spi_transfer(rate_change);
    moves_sent++;
  endtask

  task automatic wait_moves_done();
    while (u_monitor.done_count < moves_sent) begin
      @(negedge CLK);
    end
  endtask

  initial begin
    logic [63:0] value;
    logic [63:0] duration;
    logic [63:0] increment;
    logic [63:0] rate_change;
    logic [63:0] pick;
    reset = 1'b1;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    encoder_count = '0;
    lfsr_state = 32'h2d35;

    u_monitor.start_test("reset_defaults");
    repeat (3) @(posedge CLK);
    reset <= 1'b0;
    repeat (4) @(posedge CLK);
    u_monitor.end_test();

    u_monitor.start_test("config");
    for (int i = 0; i < CONFIG_ROUNDS; i++) begin
      random_bits(56, value);
      spi_transfer({CMD_MOTOR_ENABLE, value[55:0]});
      random_bits(56, value);
      spi_transfer({CMD_MOTORCONFIG, value[55:0]});
      // Divisor 0 ticks every cycle so steps could merge
      random_bits(8, value);
      spi_transfer({CMD_CLK_DIVISOR, 48'd0, value[7:1], 1'b1});
    end
    u_monitor.end_test();

    u_monitor.start_test("api_version");
    for (int i = 0; i < API_ROUNDS; i++) begin
      spi_transfer({CMD_API_VERSION, 56'd0});
      random_bits(64, value);
      spi_transfer(value);
    end
    u_monitor.end_test();

    u_monitor.start_test("random_moves");
    for (int i = 0; i < RANDOM_MOVES; i++) begin
      random_bits(4, value);
      duration = value % 13;
      random_bits(64, increment);
      random_bits(1, pick);
      random_bits(8, rate_change);
      if (!pick[0]) begin
        rate_change = '0;
      end
      random_bits(1, value);
      send_move(value[0], duration, increment, rate_change);
    end
    wait_moves_done();
    u_monitor.end_test();

    u_monitor.start_test("queue_flow");
    // Slowest ticks so the queue backs up
    spi_transfer({CMD_CLK_DIVISOR, 48'd0, 8'd255});
    for (int i = 0; i < FLOW_MOVES; i++) begin
      random_bits(64, increment);
      random_bits(1, value);
      send_move(value[0], 64'(FLOW_DURATION), increment, 64'd0);
    end
    wait_moves_done();
    // Catch any stray done pulse
    repeat (20) @(negedge CLK);
    u_monitor.end_test();

    assertion_fails = i_stepper_controller.i_move_queue.u_queue_checks.fail_count +
                      i_stepper_controller.i_dda_timer.u_timer_checks.fail_count;
    error_count = u_monitor.error_total + assertion_fails;
    $display("Totals: %0d checks, %0d monitor errors, %0d assertion failures",
             u_monitor.check_total, u_monitor.error_total, assertion_fails);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- source/command_decoder.sv
`timescale 1ns/1ps

// Host message FSM
module command_decoder
  import stepper_pkg::*;
(
  input logic CLK,
  input logic reset,
  input logic word_received,
  input logic [63:0] word_data,
  output logic [63:0] send_data,
  input logic [63:0] encoder_count,
  output logic enable,
  output logic [7:0] clock_divisor,
  output logic [7:0] current,
  output logic [2:0] microsteps,
  move_if.producer enq
);

  // Header of the message in flight, zero when idle
  logic [7:0] message_header;
  // Words already taken for this message
  logic [1:0] word_count;
  logic [7:0] cmd;
  logic awaiting_more_words;

  // Move under assembly
  move_t move_r;
  logic push_r;
  // Encoder value at header time
  logic [63:0] encoder_store;

  assign cmd = word_data[63:56];

  // Multi word messages keep their header until complete
  assign awaiting_more_words = (message_header == CMD_COORDINATED_STEP) |
                               (message_header == CMD_API_VERSION);

  always_ff @(posedge CLK) begin
    if (reset) begin
      message_header <= '0;
      word_count <= '0;
      send_data <= '0;
      push_r <= 1'b0;
      enable <= 1'b0;
      clock_divisor <= DEFAULT_DIVISOR;
      current <= DEFAULT_CURRENT;
      microsteps <= DEFAULT_MICROSTEPS;
    end else begin
      push_r <= 1'b0;
      if (word_received) begin
        // No reply unless a branch loads one
        send_data <= '0;
        if (!awaiting_more_words) begin
          message_header <= cmd;
          word_count <= 2'd1;
          case (cmd)
            CMD_MOTOR_ENABLE: begin
              enable <= word_data[0];
            end
            CMD_CLK_DIVISOR: begin
              clock_divisor <= word_data[7:0];
            end
            CMD_MOTORCONFIG: begin
              current <= word_data[15:8];
              microsteps <= word_data[2:0];
            end
            CMD_API_VERSION: begin
              // Goes out during the second word
              send_data <= {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
            end
            default: begin
              // Unknown single word, nothing to do
            end
          endcase
        end else begin
          word_count <= word_count + 1'b1;
          if (message_header == CMD_COORDINATED_STEP) begin
            case (word_count)
              2'd1: begin
                // Duration word
              end
              2'd2: begin
                // Snapshot rides back on word 4
                send_data <= encoder_store;
              end
              default: begin
                // Last word, hand off the finished move
                push_r <= 1'b1;
                word_count <= '0;
                message_header <= '0;
              end
            endcase
          end else begin
            // Second word of a two word message
            message_header <= '0;
          end
        end
      end
    end
  end

  // Payload fields and snapshot
  always_ff @(posedge CLK) begin
    if (word_received) begin
      if (!awaiting_more_words && cmd == CMD_COORDINATED_STEP) begin
        move_r.dir <= word_data[0];
        encoder_store <= encoder_count;
      end
      if (message_header == CMD_COORDINATED_STEP) begin
        case (word_count)
          2'd1: move_r.duration <= word_data;
          2'd2: move_r.increment <= word_data;
          default: move_r.incrementincrement <= word_data;
        endcase
      end
    end
  end

  assign enq.push = push_r;
  assign enq.entry = move_r;

endmodule

//--- source/dda_timer.sv
`timescale 1ns/1ps

// Second order DDA step generator
module dda_timer
  import stepper_pkg::*;
(
  input logic CLK,
  input logic reset,
  input logic [7:0] clock_divisor,
  move_if.consumer deq,
  output logic step,
  output logic dir,
  output logic move_done
);

  logic busy;
  logic pop_r;
  logic [7:0] div_count;
  logic tick;

  // Active move state
  logic [63:0] remaining;
  logic [63:0] rate;
  logic [63:0] rate_step;
  logic [63:0] phase;

  // Rate updated first, then summed into the phase
  logic [63:0] rate_next;
  logic [64:0] phase_sum;

  assign tick = busy && (remaining != '0) && (div_count == clock_divisor);
  assign rate_next = rate + rate_step;
  assign phase_sum = {1'b0, phase} + {1'b0, rate_next};

  always_ff @(posedge CLK) begin
    if (reset) begin
      busy <= 1'b0;
      pop_r <= 1'b0;
      div_count <= '0;
      step <= 1'b0;
      dir <= 1'b0;
      move_done <= 1'b0;
    end else begin
      pop_r <= 1'b0;
      step <= 1'b0;
      move_done <= 1'b0;
      if (!busy) begin
        // Grab the head entry, pop follows next cycle
        if (deq.valid) begin
          busy <= 1'b1;
          pop_r <= 1'b1;
          div_count <= '0;
          dir <= deq.entry.dir;
        end
      end else if (remaining == '0) begin
        // Zero length moves land here straight away
        busy <= 1'b0;
        move_done <= 1'b1;
      end else if (tick) begin
        div_count <= '0;
        // Carry out of the phase is one step
        step <= phase_sum[64];
      end else begin
        div_count <= div_count + 1'b1;
      end
    end
  end

  // Datapath, loaded on grab and advanced per tick
  always_ff @(posedge CLK) begin
    if (!busy && deq.valid) begin
      remaining <= deq.entry.duration;
      rate <= deq.entry.increment;
      rate_step <= deq.entry.incrementincrement;
      phase <= '0;
    end else if (tick) begin
      remaining <= remaining - 1'b1;
      rate <= rate_next;
      phase <= phase_sum[63:0];
    end
  end

  assign deq.pop = pop_r;

endmodule

//--- source/move_if.sv
`timescale 1ns/1ps

// Move handoff between decoder, queue and step generator
interface move_if
  import stepper_pkg::*;
();

  // One cycle strobe, entry sampled with it
  logic push;
  move_t entry;
  // Level, receiver cannot take more
  logic full;
  // Level, entry holds a pending move
  logic valid;
  // One cycle strobe, consumes the presented entry
  logic pop;

  // Writing side of a link
  modport producer (
    output push,
    output entry,
    output valid,
    input full,
    input pop
  );

  // Receiving side of a link
  modport consumer (
    input push,
    input entry,
    input valid,
    output full,
    output pop
  );

endinterface

//--- source/move_queue.sv
`timescale 1ns/1ps

// Circular buffer of pending moves
module move_queue
  import stepper_pkg::*;
(
  input logic CLK,
  input logic reset,
  move_if.consumer enq,
  move_if.producer deq
);

  move_t mem [MOVE_DEPTH];

  logic [MOVE_PTR_BITS-1:0] wr_ptr;
  logic [MOVE_PTR_BITS-1:0] rd_ptr;
  // One extra bit so full and empty differ
  logic [MOVE_PTR_BITS:0] count;

  logic accept;
  logic take;

  // Pushes while full are lost
  assign accept = enq.push & ~enq.full;
  assign take = deq.pop & deq.valid;

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({accept, take})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage only
  always_ff @(posedge CLK) begin
    if (accept) begin
      mem[wr_ptr] <= enq.entry;
    end
  end

  assign enq.full = (count == MOVE_DEPTH);
  assign deq.valid = (count != '0);
  // Head entry shown while valid
  assign deq.entry = mem[rd_ptr];

endmodule

//--- source/spi_word.sv
`timescale 1ns/1ps

// SPI mode 0 target, SCK oversampled on CLK
module spi_word
  import stepper_pkg::*;
(
  input logic CLK,
  input logic reset,
  input logic sck,
  input logic cs,
  input logic copi,
  output logic cipo,
  input logic [63:0] send_data,
  output logic word_received,
  output logic [63:0] word_data
);

  // Two flop synchronizers plus edge history
  logic sck_meta, sck_sync, sck_prev;
  logic cs_meta, cs_sync, cs_prev;
  logic copi_meta, copi_sync;

  logic sck_rise;
  logic sck_fall;
  logic cs_fall;

  logic [$clog2(WORD_BITS)-1:0] bit_count;
  logic last_bit;
  logic [63:0] shift_in;
  logic [63:0] shift_out;

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_meta <= 1'b0;
      sck_sync <= 1'b0;
      sck_prev <= 1'b0;
      // CS idles high so no false frame start
      cs_meta <= 1'b1;
      cs_sync <= 1'b1;
      cs_prev <= 1'b1;
      copi_meta <= 1'b0;
      copi_sync <= 1'b0;
    end else begin
      sck_meta <= sck;
      sck_sync <= sck_meta;
      sck_prev <= sck_sync;
      cs_meta <= cs;
      cs_sync <= cs_meta;
      cs_prev <= cs_sync;
      copi_meta <= copi;
      copi_sync <= copi_meta;
    end
  end

  assign sck_rise = sck_sync & ~sck_prev;
  assign sck_fall = ~sck_sync & sck_prev;
  assign cs_fall = ~cs_sync & cs_prev;

  // Receive path, MSB first
  always_ff @(posedge CLK) begin
    if (reset) begin
      bit_count <= '0;
      last_bit <= 1'b0;
      word_received <= 1'b0;
    end else begin
      // 64th bit seen this cycle
      last_bit <= sck_rise & ~cs_sync & (bit_count == WORD_BITS - 1);
      word_received <= last_bit;
      if (cs_sync) begin
        bit_count <= '0;
      end else if (sck_rise) begin
        bit_count <= bit_count + 1'b1;
      end
    end
  end

  // Payload only
  always_ff @(posedge CLK) begin
    if (sck_rise & ~cs_sync) begin
      shift_in <= {shift_in[62:0], copi_sync};
    end
    if (last_bit) begin
      word_data <= shift_in;
    end
  end

  // Transmit path, reply latched at frame start
  always_ff @(posedge CLK) begin
    if (reset) begin
      shift_out <= '0;
    end else if (cs_fall) begin
      shift_out <= send_data;
    end else if (sck_fall & ~cs_sync) begin
      // Next bit ready well before host samples on rise
      shift_out <= {shift_out[62:0], 1'b0};
    end
  end

  assign cipo = shift_out[63];

endmodule

//--- source/stepper_controller.sv
`timescale 1ns/1ps

// Single axis stepper controller, SPI host interface
module stepper_controller
  import stepper_pkg::*;
(
  input logic CLK,
  input logic reset,
  input logic sck,
  input logic cs,
  input logic copi,
  input logic [63:0] encoder_count,
  output logic cipo,
  output logic step,
  output logic dir,
  output logic enable,
  output logic move_done,
  output logic buffer_ready,
  output logic [7:0] current,
  output logic [2:0] microsteps
);

  logic [63:0] send_data;
  logic [63:0] word_data;
  logic word_received;
  logic [7:0] clock_divisor;

  // Decoder to queue
  move_if enq_bus ();
  // Queue to step generator
  move_if deq_bus ();

  spi_word i_spi_word (
    .CLK(CLK),
    .reset(reset),
    .sck(sck),
    .cs(cs),
    .copi(copi),
    .cipo(cipo),
    .send_data(send_data),
    .word_received(word_received),
    .word_data(word_data)
  );

  command_decoder i_command_decoder (
    .CLK(CLK),
    .reset(reset),
    .word_received(word_received),
    .word_data(word_data),
    .send_data(send_data),
    .encoder_count(encoder_count),
    .enable(enable),
    .clock_divisor(clock_divisor),
    .current(current),
    .microsteps(microsteps),
    .enq(enq_bus.producer)
  );

  move_queue i_move_queue (
    .CLK(CLK),
    .reset(reset),
    .enq(enq_bus.consumer),
    .deq(deq_bus.producer)
  );

  dda_timer i_dda_timer (
    .CLK(CLK),
    .reset(reset),
    .clock_divisor(clock_divisor),
    .deq(deq_bus.consumer),
    .step(step),
    .dir(dir),
    .move_done(move_done)
  );

  // Host may send a move header while this is high
  assign buffer_ready = ~enq_bus.full;

endmodule

//--- source/stepper_pkg.sv
package stepper_pkg;

  // SPI word width, one host transfer
  localparam int WORD_BITS = 64;

  // Host command codes in bits 63:56 of the first word
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE = 8'h0a;
  localparam logic [7:0] CMD_MOTORCONFIG = 8'h10;
  localparam logic [7:0] CMD_CLK_DIVISOR = 8'h14;
  localparam logic [7:0] CMD_API_VERSION = 8'hfe;

  // Firmware facing API version, replied in bits 23:0
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd3;

  // Move queue sizing
  localparam int MOVE_DEPTH = 4;
  localparam int MOVE_PTR_BITS = 2;

  // Power on configuration
  // 40 gives roughly 400 kHz ticks from a 16 MHz clock
  localparam logic [7:0] DEFAULT_DIVISOR = 8'd40;
  localparam logic [7:0] DEFAULT_CURRENT = 8'd140;
  localparam logic [2:0] DEFAULT_MICROSTEPS = 3'd2;

  // One buffered move
  // duration counts ticks
  // increment is the starting rate added to the phase each tick
  // incrementincrement is added to the rate before each phase update
  typedef struct packed {
    logic dir;
    logic [63:0] duration;
    logic [63:0] increment;
    logic [63:0] incrementincrement;
  } move_t;

endpackage

//--- sources.f
source/stepper_pkg.sv
source/move_if.sv
source/spi_word.sv
source/command_decoder.sv
source/move_queue.sv
source/dda_timer.sv
source/stepper_controller.sv
sim/stepper_assertions.sv
sim/stepper_monitor.sv
sim/stepper_tb.sv
